// ==== logic/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Width of a data word and of the pc.
`define CORE_WORD_WIDTH 32

// Register file geometry.
`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_WIDTH 5

// Data memory words, indexed by byte address bits 7 down to 2.
`define CORE_DMEM_DEPTH 64

`endif

// ==== logic/corePkg.sv ====
`include "core_defs.svh"

package corePkg;

	typedef enum logic [3:0] {
		opAddu,
		opSubu,
		opAnd,
		opOr,
		opXor,
		opSlt,
		opAddiu,
		opOri,
		opLui,
		opLw,
		opSw,
		opJal,
		opBeq,
		opBne,
		opInvalid
	} opcode_e;

	typedef enum logic [1:0] {
		srcRs,
		srcRt,
		srcNone
	} portAddrSrc_e;

	typedef enum logic [1:0] {
		wrRd,
		wrRt,
		wrR31,
		wrNone
	} wrAddrSrc_e;

	typedef enum logic [1:0] {
		dataAlu,
		dataMemory,
		dataPc
	} wrDataSrc_e;

	typedef struct packed {
		portAddrSrc_e port1Src;
		portAddrSrc_e port2Src;
		wrAddrSrc_e   wrAddrSrc;
		wrDataSrc_e   wrDataSrc;
		logic         wrEnable;
	} regCtrl_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage payloads, in pipeline order.

	typedef struct packed {
		logic [`CORE_WORD_WIDTH-1:0] pc;
		logic [`CORE_WORD_WIDTH-1:0] instruction;
	} instrIn_t;

	typedef struct packed {
		logic [`CORE_WORD_WIDTH-1:0] pc;
		logic [`CORE_WORD_WIDTH-1:0] instruction;
		opcode_e                     op;
		regCtrl_t                    regCtrl;
		logic [`CORE_WORD_WIDTH-1:0] immediate; // Already extended.
	} decoded_t;

	typedef struct packed {
		logic [`CORE_WORD_WIDTH-1:0]     pc;
		opcode_e                         op;
		logic [`CORE_WORD_WIDTH-1:0]     port1;
		logic [`CORE_WORD_WIDTH-1:0]     port2;
		logic [`CORE_WORD_WIDTH-1:0]     immediate;
		logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr;
		logic                            wrEnable;
		wrDataSrc_e                      wrDataSrc;
	} operand_t;

	typedef struct packed {
		logic [`CORE_WORD_WIDTH-1:0]     pc;
		opcode_e                         op;
		logic [`CORE_WORD_WIDTH-1:0]     aluResult;
		logic [`CORE_WORD_WIDTH-1:0]     storeData;
		logic                            branchTaken;
		logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr;
		logic                            wrEnable;
		wrDataSrc_e                      wrDataSrc;
	} executed_t;

	typedef struct packed {
		logic [`CORE_WORD_WIDTH-1:0]     pc;
		logic                            wrEnable;
		logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr;
		logic [`CORE_WORD_WIDTH-1:0]     wrData;
		logic                            branchTaken;
	} retire_t;

endpackage

// ==== logic/decodeStage.sv ====
`include "core_defs.svh"

module decodeStage (
	input  logic              clk,
	input  logic              arstN,
	input  logic              inValid,
	output logic              inReady,
	input  corePkg::instrIn_t instrIn,
	output logic              decValid,
	input  logic              decReady,
	output corePkg::decoded_t decoded
);

	logic [5:0]                  opField;
	logic [5:0]                  funct;
	logic [15:0]                 imm16;
	corePkg::opcode_e            op;
	corePkg::regCtrl_t           regCtrl;
	logic [`CORE_WORD_WIDTH-1:0] immExt;
	logic                        inFire;

	assign opField = instrIn.instruction[31:26];
	assign funct   = instrIn.instruction[5:0];
	assign imm16   = instrIn.instruction[15:0];

	// Opcode and funct to instruction class.
	always_comb begin
		case (opField)
			6'h00: begin
				case (funct)
					6'h21:   op = corePkg::opAddu;
					6'h23:   op = corePkg::opSubu;
					6'h24:   op = corePkg::opAnd;
					6'h25:   op = corePkg::opOr;
					6'h26:   op = corePkg::opXor;
					6'h2a:   op = corePkg::opSlt;
					default: op = corePkg::opInvalid;
				endcase
			end
			6'h03:   op = corePkg::opJal;
			6'h04:   op = corePkg::opBeq;
			6'h05:   op = corePkg::opBne;
			6'h09:   op = corePkg::opAddiu;
			6'h0d:   op = corePkg::opOri;
			6'h0f:   op = corePkg::opLui;
			6'h23:   op = corePkg::opLw;
			6'h2b:   op = corePkg::opSw;
			default: op = corePkg::opInvalid;
		endcase
	end

	always_comb begin
		regCtrl.port1Src  = corePkg::srcNone; // Invalid retires as a no-op.
		regCtrl.port2Src  = corePkg::srcNone;
		regCtrl.wrAddrSrc = corePkg::wrNone;
		regCtrl.wrDataSrc = corePkg::dataAlu;
		regCtrl.wrEnable  = 1'b0;
		case (op)
			corePkg::opAddu, corePkg::opSubu, corePkg::opAnd,
			corePkg::opOr, corePkg::opXor, corePkg::opSlt: begin
				regCtrl.port1Src  = corePkg::srcRs;
				regCtrl.port2Src  = corePkg::srcRt;
				regCtrl.wrAddrSrc = corePkg::wrRd;
				regCtrl.wrEnable  = 1'b1;
			end
			corePkg::opAddiu, corePkg::opOri, corePkg::opLui, corePkg::opLw: begin
				if (op != corePkg::opLui) begin
					regCtrl.port1Src = corePkg::srcRs;
				end
				regCtrl.wrAddrSrc = corePkg::wrRt;
				regCtrl.wrEnable  = 1'b1;
				if (op == corePkg::opLw) begin
					regCtrl.wrDataSrc = corePkg::dataMemory;
				end
			end
			corePkg::opSw, corePkg::opBeq, corePkg::opBne: begin
				regCtrl.port1Src = corePkg::srcRs;
				regCtrl.port2Src = corePkg::srcRt;
			end
			corePkg::opJal: begin
				regCtrl.wrAddrSrc = corePkg::wrR31;
				regCtrl.wrDataSrc = corePkg::dataPc; // Link value.
				regCtrl.wrEnable  = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (op)
			corePkg::opAddiu, corePkg::opLw, corePkg::opSw,
			corePkg::opBeq, corePkg::opBne: immExt = {{16{imm16[15]}}, imm16};
			corePkg::opOri:                 immExt = {16'b0, imm16};
			corePkg::opLui:                 immExt = {imm16, 16'b0};
			default:                        immExt = '0;
		endcase
	end

	assign inReady = !decValid || decReady;
	assign inFire  = inValid && inReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else if (inFire) begin
			decValid <= 1'b1;
		end else if (decReady) begin
			decValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inFire) begin
			decoded.pc          <= instrIn.pc;
			decoded.instruction <= instrIn.instruction;
			decoded.op          <= op;
			decoded.regCtrl     <= regCtrl;
			decoded.immediate   <= immExt;
		end
	end

endmodule

// ==== logic/registerDatapath.sv ====
`include "core_defs.svh"

module registerDatapath (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            decValid,
	output logic                            decReady,
	input  corePkg::decoded_t               decoded,
	output logic                            opValid,
	input  logic                            opReady,
	output corePkg::operand_t               operand,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] aluPendAddr,
	input  logic                            aluPendEn,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] memPendAddr,
	input  logic                            memPendEn,
	input  logic                            wbEnable,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] wbAddr,
	input  logic [`CORE_WORD_WIDTH-1:0]     wbData
);

	logic [`CORE_REG_ADDR_WIDTH-1:0] rs;
	logic [`CORE_REG_ADDR_WIDTH-1:0] rt;
	logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
	logic [`CORE_REG_ADDR_WIDTH-1:0] rd1Addr;
	logic [`CORE_REG_ADDR_WIDTH-1:0] rd2Addr;
	logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr;
	logic [`CORE_WORD_WIDTH-1:0]     rd1Data;
	logic [`CORE_WORD_WIDTH-1:0]     rd2Data;
	logic [`CORE_WORD_WIDTH-1:0]     regs [`CORE_REG_COUNT];
	logic                            selfPendEn;
	logic                            hazard;
	logic                            decFire;

	function automatic logic conflict(
		input logic [`CORE_REG_ADDR_WIDTH-1:0] readAddr,
		input logic                            pendEn,
		input logic [`CORE_REG_ADDR_WIDTH-1:0] pendAddr
	);
		return pendEn && (readAddr != '0) && (readAddr == pendAddr);
	endfunction

	assign rs = decoded.instruction[25:21];
	assign rt = decoded.instruction[20:16];
	assign rd = decoded.instruction[15:11];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address selection.

	always_comb begin
		case (decoded.regCtrl.port1Src)
			corePkg::srcRs: rd1Addr = rs;
			corePkg::srcRt: rd1Addr = rt;
			default:        rd1Addr = '0;
		endcase
		case (decoded.regCtrl.port2Src)
			corePkg::srcRs: rd2Addr = rs;
			corePkg::srcRt: rd2Addr = rt;
			default:        rd2Addr = '0;
		endcase
		case (decoded.regCtrl.wrAddrSrc)
			corePkg::wrRd:  wrAddr = rd;
			corePkg::wrRt:  wrAddr = rt;
			corePkg::wrR31: wrAddr = 5'd31;
			default:        wrAddr = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register file.

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEnable && (wbAddr != '0)) begin
			regs[wbAddr] <= wbData;
		end
	end

	assign rd1Data = (rd1Addr == '0) ? '0 : regs[rd1Addr];
	assign rd2Data = (rd2Addr == '0) ? '0 : regs[rd2Addr];

	// Writes still in flight, including the one in our own output register.
	assign selfPendEn = opValid && operand.wrEnable;
	assign hazard = decValid && (
		conflict(rd1Addr, selfPendEn, operand.wrAddr) ||
		conflict(rd2Addr, selfPendEn, operand.wrAddr) ||
		conflict(rd1Addr, aluPendEn, aluPendAddr) ||
		conflict(rd2Addr, aluPendEn, aluPendAddr) ||
		conflict(rd1Addr, memPendEn, memPendAddr) ||
		conflict(rd2Addr, memPendEn, memPendAddr));

	assign decReady = (!opValid || opReady) && !hazard;
	assign decFire  = decValid && decReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opValid <= 1'b0;
		end else if (decFire) begin
			opValid <= 1'b1;
		end else if (opReady) begin
			opValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (decFire) begin
			operand.pc        <= decoded.pc;
			operand.op        <= decoded.op;
			operand.port1     <= rd1Data;
			operand.port2     <= rd2Data;
			operand.immediate <= decoded.immediate;
			operand.wrAddr    <= wrAddr;
			operand.wrEnable  <= decoded.regCtrl.wrEnable;
			operand.wrDataSrc <= decoded.regCtrl.wrDataSrc; // Resolved in memoryStage.
		end
	end

endmodule

// ==== logic/aluStage.sv ====
`include "core_defs.svh"

module aluStage (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            opValid,
	output logic                            opReady,
	input  corePkg::operand_t               operand,
	output logic                            exValid,
	input  logic                            exReady,
	output corePkg::executed_t              executed,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] aluPendAddr,
	output logic                            aluPendEn
);

	logic [`CORE_WORD_WIDTH-1:0] result;
	logic                        portEq;
	logic                        taken;
	logic                        opFire;

	assign portEq = operand.port1 == operand.port2;

	always_comb begin
		case (operand.op)
			corePkg::opAddu:  result = operand.port1 + operand.port2;
			corePkg::opSubu:  result = operand.port1 - operand.port2;
			corePkg::opAnd:   result = operand.port1 & operand.port2;
			corePkg::opOr:    result = operand.port1 | operand.port2;
			corePkg::opXor:   result = operand.port1 ^ operand.port2;
			corePkg::opSlt:   result = {31'b0, $signed(operand.port1) < $signed(operand.port2)};
			corePkg::opAddiu,
			corePkg::opLw,
			corePkg::opSw:    result = operand.port1 + operand.immediate; // Also the address.
			corePkg::opOri:   result = operand.port1 | operand.immediate;
			corePkg::opLui:   result = operand.immediate;
			default:          result = '0;
		endcase
	end

	always_comb begin
		case (operand.op)
			corePkg::opBeq: taken = portEq;
			corePkg::opBne: taken = !portEq;
			default:        taken = 1'b0;
		endcase
	end

	assign opReady = !exValid || exReady;
	assign opFire  = opValid && opReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
		end else if (opFire) begin
			exValid <= 1'b1;
		end else if (exReady) begin
			exValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (opFire) begin
			executed.pc          <= operand.pc;
			executed.op          <= operand.op;
			executed.aluResult   <= result;
			executed.storeData   <= operand.port2;
			executed.branchTaken <= taken;
			executed.wrAddr      <= operand.wrAddr;
			executed.wrEnable    <= operand.wrEnable;
			executed.wrDataSrc   <= operand.wrDataSrc;
		end
	end

	assign aluPendAddr = executed.wrAddr;
	assign aluPendEn   = exValid && executed.wrEnable;

endmodule

// ==== logic/memoryStage.sv ====
`include "core_defs.svh"

module memoryStage (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            exValid,
	output logic                            exReady,
	input  corePkg::executed_t              executed,
	output logic                            retireValid,
	input  logic                            retireReady,
	output corePkg::retire_t                retire,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] memPendAddr,
	output logic                            memPendEn,
	output logic                            wbEnable,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] wbAddr,
	output logic [`CORE_WORD_WIDTH-1:0]     wbData
);

	localparam int DmemAddrWidth = $clog2(`CORE_DMEM_DEPTH);
	localparam logic [`CORE_WORD_WIDTH-1:0] PcStep = 4;

	logic [`CORE_WORD_WIDTH-1:0] dmem [`CORE_DMEM_DEPTH];
	logic [DmemAddrWidth-1:0]    dmemIdx;
	logic [`CORE_WORD_WIDTH-1:0] memWord;
	corePkg::executed_t          held;
	logic                        exFire;
	logic                        retireFire;

	assign exReady    = !retireValid || retireReady;
	assign exFire     = exValid && exReady;
	assign retireFire = retireValid && retireReady;
	assign dmemIdx    = executed.aluResult[DmemAddrWidth+1:2]; // Word index.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data memory. Stores land as the instruction enters.

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CORE_DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (exFire && (executed.op == corePkg::opSw)) begin
			dmem[dmemIdx] <= executed.storeData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			retireValid <= 1'b0;
		end else if (exFire) begin
			retireValid <= 1'b1;
		end else if (retireReady) begin
			retireValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (exFire) begin
			held    <= executed;
			memWord <= dmem[dmemIdx]; // Registered load.
		end
	end

	always_comb begin
		retire.pc          = held.pc;
		retire.wrEnable    = held.wrEnable;
		retire.wrAddr      = held.wrAddr;
		retire.branchTaken = held.branchTaken;
		case (held.wrDataSrc)
			corePkg::dataMemory: retire.wrData = memWord;
			corePkg::dataPc:     retire.wrData = held.pc + PcStep;
			default:             retire.wrData = held.aluResult;
		endcase
	end

	// Write-back coincides with the retire transfer.
	assign wbEnable    = retireFire && held.wrEnable;
	assign wbAddr      = held.wrAddr;
	assign wbData      = retire.wrData;
	assign memPendAddr = held.wrAddr;
	assign memPendEn   = retireValid && held.wrEnable;

endmodule

// ==== logic/coreTop.sv ====
`include "core_defs.svh"

module coreTop (
	input  logic              clk,
	input  logic              arstN,
	input  logic              inValid,
	output logic              inReady,
	input  corePkg::instrIn_t instrIn,
	output logic              retireValid,
	input  logic              retireReady,
	output corePkg::retire_t  retire
);

	logic                            decValid;
	logic                            decReady;
	corePkg::decoded_t               decoded;
	logic                            opValid;
	logic                            opReady;
	corePkg::operand_t               operand;
	logic                            exValid;
	logic                            exReady;
	corePkg::executed_t              executed;
	logic [`CORE_REG_ADDR_WIDTH-1:0] aluPendAddr;
	logic                            aluPendEn;
	logic [`CORE_REG_ADDR_WIDTH-1:0] memPendAddr;
	logic                            memPendEn;
	logic                            wbEnable;
	logic [`CORE_REG_ADDR_WIDTH-1:0] wbAddr;
	logic [`CORE_WORD_WIDTH-1:0]     wbData;

	decodeStage i_decode (
		.clk, .arstN, .inValid, .inReady, .instrIn,
		.decValid, .decReady, .decoded
	);

	// Pending writes from later stages feed the interlock.
	registerDatapath i_regs (
		.clk, .arstN, .decValid, .decReady, .decoded,
		.opValid, .opReady, .operand,
		.aluPendAddr, .aluPendEn, .memPendAddr, .memPendEn,
		.wbEnable, .wbAddr, .wbData
	);

	aluStage i_alu (
		.clk, .arstN, .opValid, .opReady, .operand,
		.exValid, .exReady, .executed, .aluPendAddr, .aluPendEn
	);

	memoryStage i_mem (
		.clk, .arstN, .exValid, .exReady, .executed,
		.retireValid, .retireReady, .retire,
		.memPendAddr, .memPendEn, .wbEnable, .wbAddr, .wbData
	);

endmodule

// ==== tb/coreTb.sv ====
`include "core_defs.svh"

module coreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [5:0] FnAddu  = 6'h21;
	localparam logic [5:0] FnSubu  = 6'h23;
	localparam logic [5:0] FnAnd   = 6'h24;
	localparam logic [5:0] FnOr    = 6'h25;
	localparam logic [5:0] FnXor   = 6'h26;
	localparam logic [5:0] FnSlt   = 6'h2a;
	localparam logic [5:0] OpBeq   = 6'h04;
	localparam logic [5:0] OpBne   = 6'h05;
	localparam logic [5:0] OpAddiu = 6'h09;
	localparam logic [5:0] OpOri   = 6'h0d;
	localparam logic [5:0] OpLui   = 6'h0f;
	localparam logic [5:0] OpLw    = 6'h23;
	localparam logic [5:0] OpSw    = 6'h2b;

	logic                        clk = 1'b0;
	logic                        arstN;
	logic                        inValid;
	logic                        inReady;
	corePkg::instrIn_t           instrIn;
	logic                        retireValid;
	logic                        retireReady;
	corePkg::retire_t            retire;

	int                          seed = 32'h4cbe_248e;
	int                          cycleCount = 0;
	int                          retiredCount = 0;
	logic                        pressureOn;
	logic                        gapsOn;
	logic [`CORE_WORD_WIDTH-1:0] pcNext;
	string                       testName;
	corePkg::retire_t            expQ[$];
	corePkg::retire_t            expRec;
	logic [`CORE_WORD_WIDTH-1:0] modelRegs [`CORE_REG_COUNT];
	logic [`CORE_WORD_WIDTH-1:0] modelMem [`CORE_DMEM_DEPTH];

	coreTop i_dut (
		.clk, .arstN, .inValid, .inReady, .instrIn,
		.retireValid, .retireReady, .retire
	);

	always #10 clk = !clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction encoders and reference model.

	function automatic logic [31:0] encodeR(input logic [5:0] funct, input int rd,
			input int rs, input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, funct};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] opc, input int rt,
			input int rs, input int imm);
		return {opc, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] encodeJal(input int target);
		return {6'h03, target[25:0]};
	endfunction

	// Executes one instruction in program order and returns its retire record.
	function automatic corePkg::retire_t refExecute(input corePkg::instrIn_t item);
		corePkg::retire_t rec;
		logic [31:0]      ins;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      simm;
		logic [31:0]      addr;
		ins  = item.instruction;
		a    = modelRegs[ins[25:21]];
		b    = modelRegs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		addr = a + simm;
		rec    = '0;
		rec.pc = item.pc;
		rec.wrAddr = ins[20:16]; // I-format default.
		case (ins[31:26])
			6'h00: begin
				rec.wrEnable = 1'b1;
				rec.wrAddr   = ins[15:11];
				case (ins[5:0])
					FnAddu:  rec.wrData = a + b;
					FnSubu:  rec.wrData = a - b;
					FnAnd:   rec.wrData = a & b;
					FnOr:    rec.wrData = a | b;
					FnXor:   rec.wrData = a ^ b;
					FnSlt:   rec.wrData = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
					default: rec.wrEnable = 1'b0;
				endcase
			end
			OpAddiu: {rec.wrEnable, rec.wrData} = {1'b1, addr};
			OpOri:   {rec.wrEnable, rec.wrData} = {1'b1, a | {16'h0, ins[15:0]}};
			OpLui:   {rec.wrEnable, rec.wrData} = {1'b1, ins[15:0], 16'h0};
			OpLw:    {rec.wrEnable, rec.wrData} = {1'b1, modelMem[addr[7:2]]};
			OpSw:    modelMem[addr[7:2]] = b;
			6'h03: begin
				rec.wrEnable = 1'b1;
				rec.wrAddr   = 5'd31;
				rec.wrData   = item.pc + 32'd4;
			end
			OpBeq:   rec.branchTaken = a == b;
			OpBne:   rec.branchTaken = a != b;
			default: ;
		endcase
		if (rec.wrEnable && rec.wrAddr != 5'd0) begin
			modelRegs[rec.wrAddr] = rec.wrData;
		end
		return rec;
	endfunction

	function automatic logic [31:0] randomInstr();
		int pick;
		int rd;
		int rs;
		int rt;
		int imm;
		pick = $unsigned($random(seed)) % 13;
		rd   = $unsigned($random(seed)) % 8; // Few registers, many dependencies.
		rs   = $unsigned($random(seed)) % 8;
		rt   = $unsigned($random(seed)) % 8;
		imm  = $random(seed);
		case (pick)
			0:       return encodeR(FnAddu, rd, rs, rt);
			1:       return encodeR(FnSubu, rd, rs, rt);
			2:       return encodeR(FnAnd, rd, rs, rt);
			3:       return encodeR(FnOr, rd, rs, rt);
			4:       return encodeR(FnXor, rd, rs, rt);
			5:       return encodeR(FnSlt, rd, rs, rt);
			6:       return encodeI(OpAddiu, rt, rs, imm);
			7:       return encodeI(OpOri, rt, rs, imm);
			8:       return encodeI(OpLui, rt, 0, imm);
			9:       return encodeI(OpLw, rt, 0, imm & 'hfc);
			10:      return encodeI(OpSw, rt, 0, imm & 'hfc);
			11:      return encodeJal(imm);
			default: return encodeI(imm[0] ? OpBeq : OpBne, rt, rs, imm);
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus.

	task automatic nextCycle();
		@(posedge clk);
		#1;
		if (pressureOn) begin
			retireReady = ($unsigned($random(seed)) % 4) != 0;
		end
	endtask

	task automatic sendInstr(input logic [31:0] word);
		corePkg::instrIn_t item;
		logic              accepted;
		item.pc          = pcNext;
		item.instruction = word;
		pcNext           = pcNext + 32'd4;
		expQ.push_back(refExecute(item));
		instrIn  = item;
		inValid  = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			#1;
			accepted = inReady; // Settled well before the edge.
			nextCycle();
		end
		inValid = 1'b0;
		if (gapsOn && ($unsigned($random(seed)) % 4) == 0) begin
			repeat ($unsigned($random(seed)) % 3 + 1) nextCycle();
		end
	endtask

	task automatic loadConst(input int r, input logic [31:0] value);
		sendInstr(encodeI(OpLui, r, 0, {16'h0, value[31:16]}));
		sendInstr(encodeI(OpOri, r, r, {16'h0, value[15:0]}));
	endtask

	task automatic waitDrain();
		while (retiredCount != expQ.size()) begin
			nextCycle();
		end
	endtask

	task automatic runRandom(input int count);
		repeat (count) sendInstr(randomInstr());
		waitDrain();
	endtask

	task automatic checkValue(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s %s: expected %h, actual %h", testName, field, expected, actual);
			$display("tests failed");
			$fatal(1, "Mismatch on %s.", field);
		end
	endtask

	// Compare on the falling edge, where a pending retire transfer is stable.
	always @(negedge clk) begin
		if (arstN && retireValid && retireReady) begin
			if (retiredCount >= expQ.size()) begin
				$display("A retire record with pc %h arrived with nothing expected", retire.pc);
				$display("tests failed");
				$fatal(1, "Extra retire record.");
			end else begin
				expRec = expQ[retiredCount];
				checkValue("pc", expRec.pc, retire.pc);
				checkValue("wrEnable", 32'(expRec.wrEnable), 32'(retire.wrEnable));
				checkValue("branchTaken", 32'(expRec.branchTaken), 32'(retire.branchTaken));
				if (expRec.wrEnable) begin
					checkValue("wrAddr", 32'(expRec.wrAddr), 32'(retire.wrAddr));
					checkValue("wrData", expRec.wrData, retire.wrData);
				end
				retiredCount++;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > 20 * expQ.size() + 200) begin
			$display("Timeout after %0d cycles, %0d of %0d records retired",
				cycleCount, retiredCount, expQ.size());
			$display("tests failed");
			$fatal(1, "Timeout.");
		end
	end

	initial begin
		arstN       = 1'b0;
		inValid     = 1'b0;
		instrIn     = '0;
		retireReady = 1'b1;
		pressureOn  = 1'b0;
		gapsOn      = 1'b0;
		pcNext      = 32'h0040_0000;
		testName    = "reset";
		for (int i = 0; i < `CORE_REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < `CORE_DMEM_DEPTH; i++) begin
			modelMem[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;
		nextCycle();

		testName = "aluOps";
		loadConst(1, 32'hffff_fff6);
		loadConst(2, 32'h0000_0007);
		loadConst(3, 32'h8000_0000);
		loadConst(4, 32'h1234_5678);
		sendInstr(encodeR(FnAddu, 10, 1, 2));
		sendInstr(encodeR(FnSubu, 11, 2, 1));
		sendInstr(encodeR(FnAnd, 12, 4, 1));
		sendInstr(encodeR(FnOr, 13, 3, 2));
		sendInstr(encodeR(FnXor, 14, 4, 1));
		sendInstr(encodeR(FnSlt, 15, 1, 2)); // Negative below positive.
		sendInstr(encodeR(FnSlt, 16, 2, 1));
		sendInstr(encodeR(FnSlt, 17, 3, 1));
		sendInstr(encodeI(OpAddiu, 18, 2, -3));
		sendInstr(encodeI(OpOri, 19, 0, 'h8001)); // Zero extension.
		sendInstr(encodeI(OpLui, 20, 0, 'hbeef));
		waitDrain();

		testName = "hazards";
		sendInstr(encodeI(OpAddiu, 5, 0, 1));
		repeat (3) sendInstr(encodeI(OpAddiu, 5, 5, 1));
		sendInstr(encodeR(FnAddu, 6, 5, 5));
		sendInstr(encodeR(FnSubu, 7, 6, 5));
		sendInstr(encodeI(OpAddiu, 0, 5, 99));
		sendInstr(encodeR(FnAddu, 8, 0, 5));
		sendInstr(encodeR(FnOr, 9, 0, 0));
		waitDrain();

		testName = "memory";
		sendInstr(encodeI(OpSw, 4, 0, 'h10));
		sendInstr(encodeI(OpLw, 21, 0, 'h10));
		sendInstr(encodeI(OpSw, 1, 0, 'h14));
		sendInstr(encodeI(OpSw, 2, 0, 'hfc));
		sendInstr(encodeI(OpLw, 22, 0, 'h14));
		sendInstr(encodeI(OpLw, 23, 0, 'hfc));
		sendInstr(encodeI(OpLw, 24, 0, 'h20));
		sendInstr(encodeI(OpAddiu, 25, 0, 'h40));
		sendInstr(encodeI(OpSw, 3, 25, 8));
		sendInstr(encodeI(OpLw, 26, 0, 'h48));
		waitDrain();

		testName = "jalBranch";
		sendInstr(encodeJal('h10));
		sendInstr(encodeR(FnAddu, 27, 31, 0));
		sendInstr(encodeI(OpBeq, 1, 1, 4));
		sendInstr(encodeI(OpBeq, 2, 1, 4));
		sendInstr(encodeI(OpBne, 2, 1, -4));
		sendInstr(encodeI(OpBne, 2, 2, -4));
		sendInstr(encodeI(OpBeq, 0, 0, 0));
		waitDrain();

		testName = "backPressure";
		pressureOn = 1'b1;
		runRandom(40);

		testName = "randomStream";
		gapsOn = 1'b1;
		runRandom(300);

		repeat (10) nextCycle();
		if (retiredCount == expQ.size()) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("Only %0d of %0d records retired", retiredCount, expQ.size());
			$display("tests failed");
			$fatal(1, "Missing retire records.");
		end
	end

endmodule

// ==== all.f ====
+incdir+logic
logic/corePkg.sv
logic/decodeStage.sv
logic/registerDatapath.sv
logic/aluStage.sv
logic/memoryStage.sv
logic/coreTop.sv
tb/coreTb.sv

// ==== Makefile ====
TOP = coreTb

sim:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
